// File: compile.f
+incdir+test
rtl/cd_pkg.sv
rtl/sector_loader.sv
rtl/sector_cache.sv
rtl/cache_dma.sv
rtl/cd_sys.sv
test/tb_cd_sys.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CD sector path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cd_sys -f compile.f -o Vtb_cd_sys
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_cd_sys 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1

// File: test/tb_cd_ref.svh
/*
 * Reference model and compare tasks for the CD sector path testbench
 * Expected header, cache words and DMA write sequences
 */
`ifndef TB_CD_REF_SVH
`define TB_CD_REF_SVH

// Header bytes 0-1 arrive in the first header word, 2-3 in the second
function automatic cd_pkg::sector_header_t expected_header(input cd_pkg::word_t w0,
	input cd_pkg::word_t w1);
	cd_pkg::sector_header_t h;
	h.b0 = w0[7:0];
	h.b1 = w0[15:8];
	h.b2 = w1[7:0];
	h.b3 = w1[15:8];
	return h;
endfunction

// Low payload byte lands at the even address, which is the high half of a cache word
function automatic cd_pkg::word_t cache_word(input cd_pkg::word_t payload);
	cd_pkg::byte_t even_byte;
	cd_pkg::byte_t odd_byte;
	even_byte = payload[7:0];
	odd_byte = payload[15:8];
	return {even_byte, odd_byte};
endfunction

function automatic cd_pkg::word_t swap_bytes(input cd_pkg::word_t w);
	return {w[7:0], w[15:8]};
endfunction

function automatic void push_write(input cd_pkg::mem_addr_t addr, input cd_pkg::word_t data);
	cd_pkg::mem_write_t w;
	w.wr = 1'b1;
	w.addr = addr;
	w.data = data;
	exp_q.push_back(w);
endfunction

// Whole write sequence of one DMA command, from the last loaded payload
function automatic void expect_writes(input cd_pkg::dma_cmd_t cmd);
	cd_pkg::mem_addr_t addr;
	int k;
	addr = cmd.addr;
	for (k = 0; k < int'(cmd.count); k++)
	begin
		case (cmd.mode)
			cd_pkg::DMA_CD_WORD:
			begin
				push_write(addr, cache_word(sent_words[k]));
				addr = addr + 24'd2;
			end
			cd_pkg::DMA_CD_BYTE:
			begin
				push_write(addr, swap_bytes(cache_word(sent_words[k])));	// Swapped first
				push_write(addr + 24'd2, cache_word(sent_words[k]));
				addr = addr + 24'd4;
			end
			default:
			begin
				push_write(addr, cmd.value);
				addr = addr + 24'd2;
			end
		endcase
	end
endfunction

// ==================================================
// Compare tasks
// ==================================================
task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
		abort_run("single bit output mismatch");
	end
endtask

task automatic compare_header(input cd_pkg::sector_header_t got,
	input cd_pkg::sector_header_t exp);
	if (got !== exp)
	begin
		$display("** Error: header = 0x%08h, expected 0x%08h", got, exp);
		abort_run("sector header mismatch");
	end
endtask

task automatic verify_mem_write(input cd_pkg::mem_write_t got, input cd_pkg::mem_write_t exp);
	if (got.addr !== exp.addr || got.data !== exp.data)
	begin
		$display("** Error: mem_wr = addr 0x%06h data 0x%04h, expected addr 0x%06h data 0x%04h",
			got.addr, got.data, exp.addr, exp.data);
		abort_run("memory write mismatch");
	end
endtask

task automatic within_margin(input string name, input int got, input int exp, input int margin);
	if (got > exp + margin || got < exp - margin)
	begin
		$display("** Error: %s = 0x%0h cycles, expected 0x%0h within %0d", name, got, exp,
			margin);
		abort_run("sector timing out of range");
	end
endtask

`endif

// File: test/tb_cd_sys.sv
/*
 * Testbench for the CD sector path
 * Loads sectors through the host port, runs the cache DMA in all
 * three modes and checks memory writes, headers and sector timing
 */
module tb_cd_sys;

	localparam int MCLK = 15000;
	localparam int SECTOR_BYTES = 64;
	localparam int SECTOR_WORDS = SECTOR_BYTES / 2;
	localparam int PERIOD_1X = MCLK / 75;	// Sector time in cycles
	localparam int WAIT_LIMIT = 4 * PERIOD_1X;

	logic clk_sys;
	logic nRESET;
	cd_pkg::host_write_t host_wr;
	cd_pkg::speed_e speed;
	cd_pkg::dma_cmd_t dma_cmd;
	logic dma_start;
	logic mem_busy;
	logic data_wr_ready;
	logic sector_ready;
	cd_pkg::sector_header_t header;
	logic dma_running;
	cd_pkg::mem_write_t mem_wr;

	int seed;
	int cycle = 0;
	int rise_cycle = 0;
	int high_len = 0;				// Last sector_ready pulse
	logic ready_q = 1'b0;
	cd_pkg::word_t sent_words [$];		// Payload of last sector loaded
	cd_pkg::mem_write_t exp_q [$];		// Writes the DMA still owes

	`include "tb_cd_ref.svh"

	cd_sys #(.MCLK(MCLK), .SECTOR_BYTES(SECTOR_BYTES)) u_dut (
		.clk_sys(clk_sys), .nRESET(nRESET), .host_wr(host_wr), .speed(speed),
		.dma_cmd(dma_cmd), .dma_start(dma_start), .mem_busy(mem_busy),
		.data_wr_ready(data_wr_ready), .sector_ready(sector_ready), .header(header),
		.dma_running(dma_running), .mem_wr(mem_wr)
	);

	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys)
		cycle <= cycle + 1;

	// ==================================================
	// Monitors
	// ==================================================
	// High time of sector_ready is half a sector period
	always @(negedge clk_sys)
	begin
		if (sector_ready && !ready_q)
			rise_cycle = cycle;
		if (!sector_ready && ready_q)
			high_len = cycle - rise_cycle;
		ready_q = sector_ready;
	end

	always @(negedge clk_sys)
	begin
		if (nRESET === 1'b1 && mem_wr.wr === 1'b1 && mem_busy === 1'b0)	// Accepted next edge
		begin
			if (exp_q.size() == 0)
				abort_run("DMA wrote to memory with no write left to expect");
			else
				verify_mem_write(mem_wr, exp_q.pop_front());
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic wait_ready(input logic level, input int limit);
		int n;
		n = 0;
		while (sector_ready !== level)
		begin
			if (n == limit)
				abort_run($sformatf("timeout waiting for sector_ready to be %0d", level));
			next_cycle();
			n++;
		end
	endtask

	task automatic wait_wr_ready(input logic level, input int limit);
		int n;
		n = 0;
		while (data_wr_ready !== level)
		begin
			if (n == limit)
				abort_run($sformatf("timeout waiting for data_wr_ready to be %0d", level));
			next_cycle();
			n++;
		end
	endtask

	// One strobe, then two idle cycles
	task automatic host_write(input logic [10:0] addr, input cd_pkg::word_t data);
		host_wr.wr = 1'b1;
		host_wr.addr = addr;
		host_wr.data = data;
		next_cycle();
		host_wr.wr = 1'b0;
		next_cycle();
		next_cycle();
	endtask

	task automatic load_sector(output cd_pkg::sector_header_t hdr);
		cd_pkg::word_t w0;
		cd_pkg::word_t w1;
		int k;
		w0 = cd_pkg::word_t'($random(seed));
		w1 = cd_pkg::word_t'($random(seed));
		sent_words.delete();
		wait_wr_ready(1'b1, WAIT_LIMIT);
		host_write(cd_pkg::HEADER_WORD0, w0);
		host_write(cd_pkg::HEADER_WORD1, w1);
		for (k = 0; k < SECTOR_WORDS; k++)
		begin
			sent_words.push_back(cd_pkg::word_t'($random(seed)));
			host_write(11'(k), sent_words[k]);	// Address is ignored
		end
		wait_wr_ready(1'b0, 8);		// Bank now filled
		hdr = expected_header(w0, w1);
	endtask

	// Filled load bank blocks the host until the swap
	task automatic hold_until_swap(input int limit);
		int n;
		n = 0;
		wait_ready(1'b0, limit);
		while (sector_ready !== 1'b1)
		begin
			check_bit("data_wr_ready", data_wr_ready, 1'b0);
			if (n == limit)
				abort_run("timeout waiting for the bank swap");
			next_cycle();
			n++;
		end
		check_bit("data_wr_ready", data_wr_ready, 1'b1);
	endtask

	task automatic run_dma(input cd_pkg::dma_cmd_t cmd, input bit busy_random);
		int n;
		expect_writes(cmd);
		dma_cmd = cmd;
		dma_start = 1'b1;
		next_cycle();
		dma_start = 1'b0;
		check_bit("dma_running", dma_running, 1'b1);
		n = 0;
		while (dma_running !== 1'b0)
		begin
			if (n == 4 * WAIT_LIMIT)
				abort_run("timeout waiting for the DMA to finish");
			if (busy_random)
				mem_busy = 1'($random(seed));
			next_cycle();
			n++;
		end
		mem_busy = 1'b0;
		check_bit("mem_wr.wr", mem_wr.wr, 1'b0);
		if (exp_q.size() != 0)
			abort_run($sformatf("%0d expected memory writes never arrived", exp_q.size()));
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial
	begin
		cd_pkg::sector_header_t hdr;
		cd_pkg::dma_cmd_t cmd;
		int high_1x;
		int high_4x;

		seed = 32'he08f;
		clk_sys = 1'b0;
		nRESET = 1'b0;
		host_wr = '0;
		speed = cd_pkg::SPEED_1X;
		dma_cmd = '0;
		dma_start = 1'b0;
		mem_busy = 1'b0;
		repeat (5) @(posedge clk_sys);
		#2;
		nRESET = 1'b1;

		check_bit("data_wr_ready", data_wr_ready, 1'b1);
		check_bit("sector_ready", sector_ready, 1'b0);
		check_bit("dma_running", dma_running, 1'b0);
		check_bit("mem_wr.wr", mem_wr.wr, 1'b0);

		// First sector, swap within two 1x periods
		load_sector(hdr);
		wait_ready(1'b1, 2 * PERIOD_1X);
		compare_header(header, hdr);
		check_bit("data_wr_ready", data_wr_ready, 1'b1);

		cmd.mode = cd_pkg::DMA_CD_WORD;
		cmd.addr = cd_pkg::mem_addr_t'($random(seed)) & 24'hfffffe;
		cmd.value = cd_pkg::word_t'($random(seed));
		cmd.count = 24'(1 + ($random(seed) & 15));
		run_dma(cmd, 1'b0);

		// Second sector while the first is read
		load_sector(hdr);
		hold_until_swap(WAIT_LIMIT);
		compare_header(header, hdr);

		cmd.mode = cd_pkg::DMA_CD_BYTE;
		cmd.addr = cd_pkg::mem_addr_t'($random(seed)) & 24'hfffffe;
		cmd.count = 24'(1 + ($random(seed) & 7));
		run_dma(cmd, 1'b0);

		cmd.mode = cd_pkg::DMA_FILL;
		cmd.addr = cd_pkg::mem_addr_t'($random(seed)) & 24'hfffffe;
		cmd.value = cd_pkg::word_t'($random(seed));
		cmd.count = 24'(1 + ($random(seed) & 31));
		run_dma(cmd, 1'b1);

		// 1x pulse from the last swap, then a swap that loads the 4x period
		wait_ready(1'b0, WAIT_LIMIT);
		next_cycle();
		high_1x = high_len;
		within_margin("sector_ready high at 1x", high_1x, PERIOD_1X / 2, 2);
		speed = cd_pkg::SPEED_4X;
		load_sector(hdr);
		wait_ready(1'b1, 2 * PERIOD_1X);
		compare_header(header, hdr);
		wait_ready(1'b0, PERIOD_1X);
		next_cycle();
		high_4x = high_len;
		// Half of a quarter 1x period
		within_margin("sector_ready high at 4x", high_4x, PERIOD_1X / 8, 2);

		next_cycle();
		$display("Verification passed");
		$finish;
	end

endmodule

// File: rtl/cd_sys.sv
/*
 * CD system controller sector path
 * Loader, two bank cache and cache DMA
 */
module cd_sys #(
	parameter int MCLK = 96671316,
	parameter int SECTOR_BYTES = 2048
) (
	input logic clk_sys,
	input logic nRESET,
	input cd_pkg::host_write_t host_wr,
	input cd_pkg::speed_e speed,
	input cd_pkg::dma_cmd_t dma_cmd,
	input logic dma_start,
	input logic mem_busy,
	output logic data_wr_ready,
	output logic sector_ready,
	output cd_pkg::sector_header_t header,
	output logic dma_running,
	output cd_pkg::mem_write_t mem_wr
);
	localparam int AW = $clog2(SECTOR_BYTES);

	// Loader to cache
	logic byte_wr;
	logic byte_bank;
	logic [AW-1:0] byte_addr;
	cd_pkg::byte_t byte_data;
	logic hdr_wr;
	logic hdr_half;
	logic hdr_bank;
	cd_pkg::word_t hdr_word;
	logic sector_done;
	logic load_bank;

	// DMA and cache read port
	logic [AW-1:0] rd_addr;
	cd_pkg::byte_t rd_data;

	sector_loader #(.SECTOR_BYTES(SECTOR_BYTES)) u_loader (
		.clk_sys(clk_sys), .nRESET(nRESET),
		.host_wr(host_wr), .data_wr_ready(data_wr_ready), .load_bank(load_bank),
		.byte_wr(byte_wr), .byte_bank(byte_bank), .byte_addr(byte_addr), .byte_data(byte_data),
		.hdr_wr(hdr_wr), .hdr_half(hdr_half), .hdr_bank(hdr_bank), .hdr_word(hdr_word),
		.sector_done(sector_done)
	);

	sector_cache #(.MCLK(MCLK), .SECTOR_BYTES(SECTOR_BYTES)) u_cache (
		.clk_sys(clk_sys), .nRESET(nRESET), .speed(speed),
		.byte_wr(byte_wr), .byte_bank(byte_bank), .byte_addr(byte_addr), .byte_data(byte_data),
		.hdr_wr(hdr_wr), .hdr_half(hdr_half), .hdr_bank(hdr_bank), .hdr_word(hdr_word),
		.sector_done(sector_done), .done_bank(byte_bank),	// Done belongs to the fill bank
		.rd_addr(rd_addr), .rd_data(rd_data),
		.load_bank(load_bank), .data_wr_ready(data_wr_ready),
		.sector_ready(sector_ready), .header(header)
	);

	cache_dma #(.SECTOR_BYTES(SECTOR_BYTES)) u_dma (
		.clk_sys(clk_sys), .nRESET(nRESET),
		.dma_cmd(dma_cmd), .dma_start(dma_start),
		.rd_data(rd_data), .mem_busy(mem_busy),
		.rd_addr(rd_addr), .dma_running(dma_running), .mem_wr(mem_wr)
	);

endmodule

// File: rtl/cache_dma.sv
/*
 * Cache DMA
 * Copies the read bank as words or odd bytes to the memory write
 * port, or fills memory with a constant word
 */
module cache_dma #(
	parameter int SECTOR_BYTES = 2048
) (
	input logic clk_sys,
	input logic nRESET,
	input cd_pkg::dma_cmd_t dma_cmd,
	input logic dma_start,
	input cd_pkg::byte_t rd_data,
	input logic mem_busy,
	output logic [$clog2(SECTOR_BYTES)-1:0] rd_addr,
	output logic dma_running,
	output cd_pkg::mem_write_t mem_wr
);
	typedef enum logic [2:0] {
		IDLE,
		START,			// Loop base, picks next step
		CACHE_RD_HI,
		CACHE_RD_LO,
		WR,
		WR_WAIT,
		NEXT			// One word done
	} state_e;

	state_e state;
	cd_pkg::dma_mode_e mode;
	cd_pkg::word_t fill_value;
	cd_pkg::word_t rd_word;		// Word assembled from cache
	logic [23:0] words_left;
	logic [1:0] io_cnt;			// Step inside one word

	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			state <= IDLE;
			dma_running <= 1'b0;
			mem_wr.wr <= 1'b0;
			io_cnt <= 2'd0;
			words_left <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				if (dma_start)
				begin
					mode <= dma_cmd.mode;
					fill_value <= dma_cmd.value;
					words_left <= dma_cmd.count;
					mem_wr.addr <= dma_cmd.addr;
					rd_addr <= '0;			// Always from byte 0
					io_cnt <= 2'd0;
					dma_running <= 1'b1;
					state <= START;
				end

				START:
				begin
					if (words_left == 24'd0)
					begin
						dma_running <= 1'b0;
						state <= IDLE;
					end
					else
					begin
						case (mode)
							cd_pkg::DMA_CD_WORD:
							case (io_cnt)
								2'd0:
								begin
									rd_addr <= rd_addr + 1'b1;	// Odd byte in flight next
									state <= CACHE_RD_HI;
								end
								2'd1:
								begin
									mem_wr.data <= rd_word;
									state <= WR;
								end
								default: state <= NEXT;
							endcase

							cd_pkg::DMA_CD_BYTE:
							case (io_cnt)
								2'd0:
								begin
									rd_addr <= rd_addr + 1'b1;
									state <= CACHE_RD_HI;
								end
								2'd1:
								begin
									mem_wr.data <= {rd_word[7:0], rd_word[15:8]};	// Swapped first
									state <= WR;
								end
								2'd2:
								begin
									mem_wr.data <= rd_word;
									state <= WR;
								end
								default: state <= NEXT;
							endcase

							cd_pkg::DMA_FILL:
							if (io_cnt == 2'd0)
							begin
								mem_wr.data <= fill_value;
								state <= WR;
							end
							else
								state <= NEXT;

							default: state <= NEXT;
						endcase
					end
				end

				CACHE_RD_HI:
				begin
					rd_word[15:8] <= rd_data;	// Even byte
					state <= CACHE_RD_LO;
				end

				CACHE_RD_LO:
				begin
					rd_word[7:0] <= rd_data;	// Odd byte
					rd_addr <= rd_addr + 1'b1;	// Next even byte
					io_cnt <= io_cnt + 1'b1;
					state <= START;
				end

				WR:
				begin
					mem_wr.wr <= 1'b1;
					state <= WR_WAIT;
				end

				WR_WAIT:
				if (!mem_busy)
				begin
					// Write accepted this cycle
					mem_wr.wr <= 1'b0;
					mem_wr.addr <= mem_wr.addr + 24'd2;
					io_cnt <= io_cnt + 1'b1;
					state <= START;
				end

				NEXT:
				begin
					words_left <= words_left - 1'b1;
					io_cnt <= 2'd0;
					state <= START;
				end

				default: state <= IDLE;
			endcase
		end
	end

	a_wr_only_running: assert property (@(posedge clk_sys) disable iff (!nRESET)
		mem_wr.wr |-> dma_running);

endmodule

// File: rtl/sector_cache.sv
/*
 * Two bank sector cache
 * Byte memory with per bank headers, filled flags and the
 * sector time counter that swaps read and load banks
 */
module sector_cache #(
	parameter int MCLK = 96671316,
	parameter int SECTOR_BYTES = 2048
) (
	input logic clk_sys,
	input logic nRESET,
	input cd_pkg::speed_e speed,
	input logic byte_wr,
	input logic byte_bank,
	input logic [$clog2(SECTOR_BYTES)-1:0] byte_addr,
	input cd_pkg::byte_t byte_data,
	input logic hdr_wr,
	input logic hdr_half,
	input logic hdr_bank,
	input cd_pkg::word_t hdr_word,
	input logic sector_done,
	input logic done_bank,
	input logic [$clog2(SECTOR_BYTES)-1:0] rd_addr,
	output cd_pkg::byte_t rd_data,
	output logic load_bank,
	output logic data_wr_ready,
	output logic sector_ready,
	output cd_pkg::sector_header_t header
);
	localparam int TW = $clog2(MCLK / 75 + 1);

	// Sector periods in clk_sys cycles
	localparam logic [TW-1:0] SECTOR_TIME_1X = TW'(MCLK / 75);
	localparam logic [TW-1:0] SECTOR_TIME_2X = TW'(MCLK / 150);
	localparam logic [TW-1:0] SECTOR_TIME_3X = TW'(MCLK / 225);
	localparam logic [TW-1:0] SECTOR_TIME_4X = TW'(MCLK / 300);

	cd_pkg::byte_t cache_mem [0:2*SECTOR_BYTES-1];
	cd_pkg::sector_header_t hdr_q [0:1];

	logic rd_bank;
	logic [1:0] filled;
	logic [TW-1:0] time_cnt;
	logic [TW-1:0] period;
	logic [TW-1:0] period_sel;

	assign load_bank = ~rd_bank;
	assign data_wr_ready = ~filled[load_bank];
	assign header = hdr_q[rd_bank];

	always_comb
	begin
		case (speed)
			cd_pkg::SPEED_1X: period_sel = SECTOR_TIME_1X;
			cd_pkg::SPEED_2X: period_sel = SECTOR_TIME_2X;
			cd_pkg::SPEED_3X: period_sel = SECTOR_TIME_3X;
			default: period_sel = SECTOR_TIME_4X;
		endcase
	end

	// ==================================================
	// Storage
	// ==================================================
	always_ff @(posedge clk_sys)
	begin
		if (byte_wr)
			cache_mem[{byte_bank, byte_addr}] <= byte_data;
		rd_data <= cache_mem[{rd_bank, rd_addr}];	// One cycle read

		if (hdr_wr)
		begin
			if (hdr_half)
				{hdr_q[hdr_bank].b3, hdr_q[hdr_bank].b2} <= hdr_word;
			else
				{hdr_q[hdr_bank].b1, hdr_q[hdr_bank].b0} <= hdr_word;
		end
	end

	// ==================================================
	// Sector timer and bank swap
	// ==================================================
	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			rd_bank <= 1'b0;
			filled <= 2'b00;
			time_cnt <= '0;
			period <= SECTOR_TIME_1X;	// First period always 1x
			sector_ready <= 1'b0;
		end
		else
		begin
			if (time_cnt == (period >> 1))
				sector_ready <= 1'b0;

			if (time_cnt < period)
				time_cnt <= time_cnt + 1'b1;
			else if (filled[load_bank])
			begin
				filled[rd_bank] <= 1'b0;	// Old sector consumed
				rd_bank <= ~rd_bank;
				sector_ready <= 1'b1;
				time_cnt <= '0;
				period <= period_sel;
			end

			if (sector_done)
				filled[done_bank] <= 1'b1;
		end
	end

	// Loader must never touch the bank being read
	a_wr_not_rd_bank: assert property (@(posedge clk_sys) disable iff (!nRESET)
		byte_wr |-> byte_bank != rd_bank);

endmodule

// File: rtl/sector_loader.sv
/*
 * Sector loader
 * Takes host word writes, captures the four header bytes and
 * splits each payload word into two cache byte writes
 */
module sector_loader #(
	parameter int SECTOR_BYTES = 2048
) (
	input logic clk_sys,
	input logic nRESET,
	input cd_pkg::host_write_t host_wr,
	input logic data_wr_ready,
	input logic load_bank,
	output logic byte_wr,
	output logic byte_bank,
	output logic [$clog2(SECTOR_BYTES)-1:0] byte_addr,
	output cd_pkg::byte_t byte_data,
	output logic hdr_wr,
	output logic hdr_half,
	output logic hdr_bank,
	output cd_pkg::word_t hdr_word,
	output logic sector_done
);
	localparam int AW = $clog2(SECTOR_BYTES);

	typedef enum logic [2:0] {IDLE, HEADER_HI, PAYLOAD, SECOND_BYTE, DONE} state_e;

	state_e state;
	logic bank;				// Bank being filled
	logic [AW-1:0] byte_cnt;
	cd_pkg::byte_t hi_byte;	// Odd byte waiting for its cycle
	logic hdr0_hit;
	logic hdr1_hit;

	assign hdr0_hit = host_wr.wr & data_wr_ready & (state == IDLE) &
	                  (host_wr.addr == cd_pkg::HEADER_WORD0);
	assign hdr1_hit = host_wr.wr & (state == HEADER_HI) &
	                  (host_wr.addr == cd_pkg::HEADER_WORD1);

	// Header goes straight to the cache registers
	assign hdr_wr = hdr0_hit | hdr1_hit;
	assign hdr_half = (state == HEADER_HI);
	assign hdr_bank = (state == IDLE) ? load_bank : bank;
	assign hdr_word = host_wr.data;

	// Even byte in the write cycle, odd byte one cycle later
	assign byte_wr = ((state == PAYLOAD) & host_wr.wr) | (state == SECOND_BYTE);
	assign byte_bank = bank;
	assign byte_addr = byte_cnt;
	assign byte_data = (state == SECOND_BYTE) ? hi_byte : host_wr.data[7:0];

	assign sector_done = (state == DONE);

	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			state <= IDLE;
			bank <= 1'b0;
			byte_cnt <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				if (hdr0_hit)
				begin
					bank <= load_bank;	// Free bank at sector start
					state <= HEADER_HI;
				end

				HEADER_HI:
				if (hdr1_hit)
				begin
					byte_cnt <= '0;
					state <= PAYLOAD;
				end

				PAYLOAD:
				if (host_wr.wr)
				begin
					// Address of payload writes is don't care
					hi_byte <= host_wr.data[15:8];
					byte_cnt <= byte_cnt + 1'b1;
					state <= SECOND_BYTE;
				end

				SECOND_BYTE:
				begin
					if (byte_cnt == AW'(SECTOR_BYTES - 1))
						state <= DONE;
					else
					begin
						byte_cnt <= byte_cnt + 1'b1;
						state <= PAYLOAD;
					end
				end

				DONE: state <= IDLE;	// One cycle done pulse

				default: state <= IDLE;
			endcase
		end
	end

	a_no_idle_write: assert property (@(posedge clk_sys) disable iff (!nRESET)
		byte_wr |-> state != IDLE);

endmodule

// File: rtl/cd_pkg.sv
/*
 * CD sector path shared definitions
 * Host word writes, sector header, DMA command and memory write formats
 */
package cd_pkg;

	// ==================================================
	// Host sector layout
	// ==================================================
	localparam logic [10:0] HEADER_WORD0 = 11'd6;	// Header bytes 0-1
	localparam logic [10:0] HEADER_WORD1 = 11'd7;	// Header bytes 2-3

	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;
	typedef logic [23:0] mem_addr_t;

	typedef struct packed {
		logic wr;			// One cycle strobe
		logic [10:0] addr;	// Word address
		word_t data;
	} host_write_t;

	typedef struct packed {
		byte_t b3;
		byte_t b2;
		byte_t b1;
		byte_t b0;
	} sector_header_t;

	// ==================================================
	// DMA and memory port
	// ==================================================
	typedef enum logic [1:0] {
		DMA_CD_WORD,	// Cache words to memory
		DMA_CD_BYTE,	// Cache bytes to odd bytes
		DMA_FILL		// Constant word fill
	} dma_mode_e;

	typedef struct packed {
		dma_mode_e mode;
		mem_addr_t addr;
		word_t value;
		logic [23:0] count;	// In words
	} dma_cmd_t;

	typedef struct packed {
		logic wr;
		mem_addr_t addr;
		word_t data;
	} mem_write_t;

	typedef enum logic [1:0] {SPEED_1X, SPEED_2X, SPEED_3X, SPEED_4X} speed_e;

endpackage
